// File: rtl/radio_consts.svh
`ifndef RADIO_CONSTS_SVH
`define RADIO_CONSTS_SVH

// --------------------
// Channel count
// --------------------

// Receive channels served by the core
`define RADIO_NR 4

// --------------------
// NCO scaling, 76.8 MHz clock
// --------------------

// 2^57 / clock frequency
`define RADIO_FREQ_M2 32'd1876499845
// Rounding term, 2^24
`define RADIO_FREQ_M3 32'd16777216

// --------------------
// Transmit levels
// --------------------

// Peak CW level, 8x the CORDIC input limit
`define RADIO_CW_MAX 18'h26c00
// VNA carrier amplitude into the CORDIC
`define RADIO_VNA_LEVEL 16'h4d80

// Command addresses
`define RADIO_ADDR_CTRL 6'h00
`define RADIO_ADDR_VNA 6'h09
`define RADIO_ADDR_TX0 6'h01
`define RADIO_ADDR_RX0 6'h02

`endif

// File: rtl/radio_pkg.sv
package radio_pkg;

  // --------------------
  // Command bus
  // --------------------

  // One addressed command word
  typedef struct packed {
    logic [5:0]  addr;
    logic [31:0] data;
  } cmd_req_t;

  // Control register set
  typedef struct packed {
    logic [4:0] last_chan;
    logic       duplex;
    logic       vna;
  } radio_ctrl_t;

  // Frequency pipeline pacing strobes
  typedef struct packed {
    // Capture phase word and address
    logic latch;
    // Apply captured word to a channel
    logic commit;
  } freq_step_t;

  // --------------------
  // Sample types
  // --------------------

  // Transmit baseband pair
  typedef struct packed {
    logic signed [15:0] i;
    logic signed [15:0] q;
  } iq16_t;

  // Receiver output pair
  typedef struct packed {
    logic [23:0] i;
    logic [23:0] q;
  } rx_sample_t;

endpackage

// File: rtl/cmd_decoder.sv
`timescale 1ns/1ns

`include "radio_consts.svh"

module cmd_decoder import radio_pkg::*; (
  input  logic        clk,
  input  logic        rst_n_i,
  input  cmd_req_t    cmd_req_i,
  input  logic        cmd_rqst_i,
  output logic        cmd_ack_o,
  output radio_ctrl_t ctrl_o,
  output freq_step_t  step_o
);

  // Gray-style walk through the frequency cycles
  typedef enum logic [1:0] {
    CMD_IDLE  = 2'b00,
    CMD_FREQ1 = 2'b01,
    CMD_FREQ2 = 2'b11,
    CMD_FREQ3 = 2'b10
  } cmd_state_t;

  cmd_state_t  state_q;
  cmd_state_t  state_d;
  radio_ctrl_t ctrl_q;
  radio_ctrl_t ctrl_d;
  logic        is_freq;

  // --------------------
  // Address classes
  // --------------------

  // TX0 and RX 0..6 at 0x01-0x08, upper receivers at 0x12-0x16
  always_comb begin
    is_freq = 1'b0;
    if ((cmd_req_i.addr >= 6'h01) && (cmd_req_i.addr <= 6'h08)) begin
      is_freq = 1'b1;
    end
    if ((cmd_req_i.addr >= 6'h12) && (cmd_req_i.addr <= 6'h16)) begin
      is_freq = 1'b1;
    end
  end

  // --------------------
  // Next state and control fields
  // --------------------

  always_comb begin
    state_d = state_q;
    ctrl_d  = ctrl_q;
    case (state_q)
      CMD_IDLE: begin
        // Only accepted while idle
        if (cmd_rqst_i) begin
          if (is_freq) begin
            state_d = CMD_FREQ1;
          end else if (cmd_req_i.addr == `RADIO_ADDR_CTRL) begin
            // Receiver count and duplex, no acknowledge
            ctrl_d.last_chan = cmd_req_i.data[7:3];
            ctrl_d.duplex    = cmd_req_i.data[2];
          end else if (cmd_req_i.addr == `RADIO_ADDR_VNA) begin
            ctrl_d.vna = cmd_req_i.data[23];
          end
        end
      end
      // Wait cycle for the multiplier
      CMD_FREQ1: state_d = CMD_FREQ2;
      // Phase word captured here
      CMD_FREQ2: state_d = CMD_FREQ3;
      // Committed to a channel, then back to idle
      CMD_FREQ3: state_d = CMD_IDLE;
      default:   state_d = CMD_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= CMD_IDLE;
      ctrl_q  <= '0;
    end else begin
      state_q <= state_d;
      ctrl_q  <= ctrl_d;
    end
  end

  // Strobes decoded from state
  assign step_o.latch  = (state_q == CMD_FREQ2);
  assign step_o.commit = (state_q == CMD_FREQ3);
  // Acknowledge on the commit cycle only
  assign cmd_ack_o     = (state_q == CMD_FREQ3);
  assign ctrl_o        = ctrl_q;

endmodule

// File: rtl/freq_word_calc.sv
`timescale 1ns/1ns

`include "radio_consts.svh"

module freq_word_calc import radio_pkg::*; #(
  parameter int NR = `RADIO_NR
) (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  cmd_req_t             cmd_req_i,
  input  radio_ctrl_t          ctrl_i,
  input  freq_step_t           step_i,
  output logic [31:0]          tx_phase_o,
  output logic [NR-1:0][31:0]  rx_phase_o
);

  logic [63:0]         freq_prod;
  logic [31:0]         word_q;
  logic [5:0]          addr_q;
  logic                simplex;
  logic [31:0]         tx_phase_q;
  logic [NR-1:0][31:0] rx_phase_q;

  // Command address of receive channel c, c >= 1
  function automatic logic [5:0] chan_addr(input int c);
    logic [5:0] a;
    if (c < 7) begin
      a = 6'(c + 2);
    end else begin
      a = 6'(c + 11);
    end
    return a;
  endfunction

  // --------------------
  // Phase word
  // --------------------

  // Data times 2^57/fclk, rounded; word is bits 56:25
  // Two cycles pass before the latch strobe
  assign freq_prod = 64'(cmd_req_i.data) * 64'(`RADIO_FREQ_M2) + 64'(`RADIO_FREQ_M3);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      word_q <= '0;
      addr_q <= '0;
    end else if (step_i.latch) begin
      word_q <= freq_prod[56:25];
      addr_q <= cmd_req_i.addr;
    end
  end

  // Single receiver and no duplex ties RX0 to TX0
  assign simplex = !ctrl_i.duplex && (ctrl_i.last_chan == 5'd0);

  // --------------------
  // Channel registers
  // --------------------

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tx_phase_q <= '0;
      rx_phase_q <= '0;
    end else if (step_i.commit) begin
      // TX0, and RX0 too when simplex
      if (addr_q == `RADIO_ADDR_TX0) begin
        tx_phase_q <= word_q;
        if (simplex) begin
          rx_phase_q[0] <= word_q;
        end
      end
      // RX0 follows the current TX0 when simplex
      if (addr_q == `RADIO_ADDR_RX0) begin
        if (simplex) begin
          rx_phase_q[0] <= tx_phase_q;
        end else begin
          rx_phase_q[0] <= word_q;
        end
      end
      // Remaining receivers
      for (int c = 1; c < NR; c++) begin
        if (addr_q == chan_addr(c)) begin
          rx_phase_q[c] <= word_q;
        end
      end
    end
  end

  assign tx_phase_o = tx_phase_q;
  assign rx_phase_o = rx_phase_q;

endmodule

// File: rtl/rx_upstream.sv
`timescale 1ns/1ns

`include "radio_consts.svh"

module rx_upstream import radio_pkg::*; #(
  parameter int NR = `RADIO_NR
) (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  radio_ctrl_t           ctrl_i,
  input  rx_sample_t [NR-1:0]   rx_samples_i,
  input  logic                  rx_strobe_i,
  input  logic                  rx_tready_i,
  output logic [23:0]           rx_tdata_o,
  output logic                  rx_tvalid_o,
  output logic                  rx_tlast_o
);

  // Frame states
  typedef enum logic [1:0] {
    UP_WAIT = 2'b00,
    UP_I    = 2'b01,
    UP_Q    = 2'b10
  } up_state_t;

  up_state_t  state_q;
  logic [4:0] chan_q;
  rx_sample_t chan_sample;
  logic       last_chan;

  // --------------------
  // Frame sequencer
  // --------------------

  // Final channel of the frame reached
  assign last_chan = (chan_q >= ctrl_i.last_chan);

  // Ready is looked at only together with the strobe
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= UP_WAIT;
      chan_q  <= '0;
    end else begin
      case (state_q)
        UP_WAIT: begin
          chan_q <= '0;
          if (rx_strobe_i && rx_tready_i) begin
            state_q <= UP_I;
          end
        end
        UP_I: state_q <= UP_Q;
        UP_Q: begin
          // Last Q closes the frame
          if (last_chan) begin
            state_q <= UP_WAIT;
          end else begin
            chan_q  <= chan_q + 5'd1;
            state_q <= UP_I;
          end
        end
        default: state_q <= UP_WAIT;
      endcase
    end
  end

  // --------------------
  // Beat data
  // --------------------

  // Sample pair of the current channel
  always_comb begin
    chan_sample = rx_samples_i[0];
    for (int c = 1; c < NR; c++) begin
      if (chan_q == 5'(c)) begin
        chan_sample = rx_samples_i[c];
      end
    end
  end

  assign rx_tvalid_o = (state_q != UP_WAIT);
  assign rx_tdata_o  = (state_q == UP_Q) ? chan_sample.q : chan_sample.i;
  assign rx_tlast_o  = (state_q == UP_Q) && last_chan;

endmodule

// File: rtl/tx_baseband.sv
`timescale 1ns/1ns

`include "radio_consts.svh"

module tx_baseband import radio_pkg::*; (
  input  logic        clk,
  input  logic        rst_n_i,
  input  radio_ctrl_t ctrl_i,
  input  logic        cw_keydown_i,
  input  iq16_t       tx_sample_i,
  input  logic        tx_strobe_i,
  input  logic [31:0] tx_phase_i,
  input  logic [31:0] rx0_phase_i,
  output iq16_t       tx_iq_o,
  output logic [31:0] tx_phase_word_o
);

  // CW envelope states
  typedef enum logic [1:0] {
    CW_IDLE = 2'b00,
    CW_RISE = 2'b01,
    CW_FALL = 2'b11
  } cw_state_t;

  cw_state_t   cw_state_q;
  logic [17:0] cw_level_q;
  logic        cw_active;
  iq16_t       host_q;
  iq16_t       host_sel;
  iq16_t       iq_d;

  // --------------------
  // CW envelope
  // --------------------

  // Linear ramp, one step per clock
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cw_state_q <= CW_IDLE;
      cw_level_q <= '0;
    end else begin
      case (cw_state_q)
        CW_IDLE: begin
          cw_level_q <= '0;
          if (cw_keydown_i) begin
            cw_state_q <= CW_RISE;
          end
        end
        CW_RISE: begin
          // Hold at peak while key stays down
          if (cw_level_q != `RADIO_CW_MAX) begin
            cw_level_q <= cw_level_q + 18'd1;
          end
          if (!cw_keydown_i) begin
            cw_state_q <= CW_FALL;
          end
        end
        CW_FALL: begin
          // Key ignored until the ramp reaches zero
          if (cw_level_q == 18'd0) begin
            cw_state_q <= CW_IDLE;
          end else begin
            cw_level_q <= cw_level_q - 18'd1;
          end
        end
        default: cw_state_q <= CW_IDLE;
      endcase
    end
  end

  assign cw_active = (cw_state_q != CW_IDLE);

  // --------------------
  // Host sample and output select
  // --------------------

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      host_q <= '0;
    end else if (tx_strobe_i) begin
      host_q <= tx_sample_i;
    end
  end

  // New sample bypasses the hold register
  assign host_sel = tx_strobe_i ? tx_sample_i : host_q;

  always_comb begin
    iq_d = host_sel;
    if (ctrl_i.vna) begin
      iq_d.i = `RADIO_VNA_LEVEL;
      iq_d.q = '0;
    end else if (cw_active) begin
      // Level / 8 keeps I inside the CORDIC range
      iq_d.i = {1'b0, cw_level_q[17:3]};
      iq_d.q = '0;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tx_iq_o         <= '0;
      tx_phase_word_o <= '0;
    end else begin
      tx_iq_o <= iq_d;
      // VNA transmits on the RX0 frequency
      tx_phase_word_o <= ctrl_i.vna ? rx0_phase_i : tx_phase_i;
    end
  end

endmodule

// File: rtl/radio_core.sv
`timescale 1ns/1ns

`include "radio_consts.svh"

module radio_core import radio_pkg::*; (
  input  logic                         clk,
  input  logic                         rst_n_i,
  // Command slave
  input  cmd_req_t                     cmd_req_i,
  input  logic                         cmd_rqst_i,
  output logic                         cmd_ack_o,
  // Transmit
  input  logic                         cw_keydown_i,
  input  iq16_t                        tx_sample_i,
  input  logic                         tx_strobe_i,
  output iq16_t                        tx_iq_o,
  output logic [31:0]                  tx_phase_word_o,
  // Receive
  input  rx_sample_t [`RADIO_NR-1:0]   rx_samples_i,
  input  logic                         rx_strobe_i,
  input  logic                         rx_tready_i,
  output logic [23:0]                  rx_tdata_o,
  output logic                         rx_tvalid_o,
  output logic                         rx_tlast_o,
  output logic [`RADIO_NR-1:0][31:0]   rx_phase_o
);

  radio_ctrl_t               ctrl;
  freq_step_t                step;
  logic [31:0]               tx_phase;
  logic [`RADIO_NR-1:0][31:0] rx_phase;

  // --------------------
  // Command and frequency
  // --------------------

  cmd_decoder u_cmd_decoder (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .cmd_req_i  (cmd_req_i),
    .cmd_rqst_i (cmd_rqst_i),
    .cmd_ack_o  (cmd_ack_o),
    .ctrl_o     (ctrl),
    .step_o     (step)
  );

  freq_word_calc #(.NR(`RADIO_NR)) u_freq_word_calc (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .cmd_req_i  (cmd_req_i),
    .ctrl_i     (ctrl),
    .step_i     (step),
    .tx_phase_o (tx_phase),
    .rx_phase_o (rx_phase)
  );

  // --------------------
  // Datapaths
  // --------------------

  rx_upstream #(.NR(`RADIO_NR)) u_rx_upstream (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .ctrl_i       (ctrl),
    .rx_samples_i (rx_samples_i),
    .rx_strobe_i  (rx_strobe_i),
    .rx_tready_i  (rx_tready_i),
    .rx_tdata_o   (rx_tdata_o),
    .rx_tvalid_o  (rx_tvalid_o),
    .rx_tlast_o   (rx_tlast_o)
  );

  tx_baseband u_tx_baseband (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .ctrl_i          (ctrl),
    .cw_keydown_i    (cw_keydown_i),
    .tx_sample_i     (tx_sample_i),
    .tx_strobe_i     (tx_strobe_i),
    .tx_phase_i      (tx_phase),
    .rx0_phase_i     (rx_phase[0]),
    .tx_iq_o         (tx_iq_o),
    .tx_phase_word_o (tx_phase_word_o)
  );

  // Receiver NCO words leave the core
  assign rx_phase_o = rx_phase;

endmodule

// File: bench/radio_tb.sv
`timescale 1ns/1ns

`include "radio_consts.svh"

module radio_tb import radio_pkg::*; ();

  localparam int NR = `RADIO_NR;
  localparam int PERIOD = 40;
  // Two full CW ramps plus margin for the shorter tests
  localparam int RUN_CYCLES = 2 * (2 * `RADIO_CW_MAX + 400) + 20000;

  logic clk;
  logic rst_n_i;
  cmd_req_t cmd_req;
  logic cmd_rqst;
  logic cmd_ack;
  logic cw_keydown;
  logic tx_strobe;
  logic rx_strobe;
  logic rx_tready;
  logic rx_tvalid;
  logic rx_tlast;
  logic [23:0] rx_tdata;
  iq16_t tx_sample;
  iq16_t tx_iq;
  logic [31:0] tx_phase_word;
  rx_sample_t [NR-1:0] rx_samples;
  logic [NR-1:0][31:0] rx_phase;

  // Reference model state
  logic [31:0] m_tx;
  logic [NR-1:0][31:0] m_rx;
  logic [4:0] m_last;
  logic m_duplex;
  logic m_vna;
  // CW model: 0 idle, 1 rise, 2 fall
  logic [1:0] m_cw;
  logic [17:0] m_level;
  iq16_t m_host;
  int errs;
  int test_errs;
  int tests;
  int failed;
  int seed;

  radio_core UUT (
    .clk(clk),
    .rst_n_i(rst_n_i),
    .cmd_req_i(cmd_req),
    .cmd_rqst_i(cmd_rqst),
    .cmd_ack_o(cmd_ack),
    .cw_keydown_i(cw_keydown),
    .tx_sample_i(tx_sample),
    .tx_strobe_i(tx_strobe),
    .tx_iq_o(tx_iq),
    .tx_phase_word_o(tx_phase_word),
    .rx_samples_i(rx_samples),
    .rx_strobe_i(rx_strobe),
    .rx_tready_i(rx_tready),
    .rx_tdata_o(rx_tdata),
    .rx_tvalid_o(rx_tvalid),
    .rx_tlast_o(rx_tlast),
    .rx_phase_o(rx_phase)
  );

  initial clk = 1'b0;
  always #(PERIOD / 2) clk = ~clk;

  // Acknowledge never lasts two cycles
  ack_pulse: assert property (@(posedge clk) disable iff (!rst_n_i) cmd_ack |=> !cmd_ack)
    else begin
      $display("ERR t=%0t cmd_ack_o expected 0 got 1", $time);
      errs++;
    end

  // --------------------
  // Helpers
  // --------------------

  task automatic check_value(input string name, input logic [47:0] exp, input logic [47:0] act);
    assert (act === exp) else begin
      $display("ERR t=%0t %s expected %0h got %0h", $time, name, exp, act);
      errs++;
    end
  endtask

  // Bits 56:25 of data times 2^57/fclk plus rounding
  function automatic logic [31:0] phase_model(input logic [31:0] data);
    logic [63:0] prod;
    prod = {32'd0, data} * 64'(`RADIO_FREQ_M2) + 64'(`RADIO_FREQ_M3);
    return prod[56:25];
  endfunction

  function automatic logic [5:0] rx_addr(input int c);
    return (c < 7) ? 6'(c + 2) : 6'(c + 11);
  endfunction

  // One clock; registered transmit outputs follow the pre-edge model
  task automatic tick();
    iq16_t exp_iq;
    logic [31:0] exp_pw;
    exp_iq = tx_strobe ? tx_sample : m_host;
    if (m_vna) begin
      exp_iq = {16'(`RADIO_VNA_LEVEL), 16'd0};
    end else if (m_cw != 2'd0) begin
      exp_iq = {16'(m_level >> 3), 16'd0};
    end
    exp_pw = m_vna ? m_rx[0] : m_tx;
    if (rst_n_i) begin
      if (tx_strobe) begin
        m_host = tx_sample;
      end
      case (m_cw)
        2'd0: begin
          m_level = '0;
          m_cw = cw_keydown ? 2'd1 : 2'd0;
        end
        2'd1: begin
          if (m_level < `RADIO_CW_MAX) begin
            m_level = m_level + 18'd1;
          end
          m_cw = cw_keydown ? 2'd1 : 2'd2;
        end
        default: begin
          if (m_level == '0) begin
            m_cw = 2'd0;
          end else begin
            m_level = m_level - 18'd1;
          end
        end
      endcase
    end
    @(posedge clk);
    #2;
    if (rst_n_i) begin
      check_value("tx_iq_o", 48'(exp_iq), 48'(tx_iq));
      check_value("tx_phase_word_o", 48'(exp_pw), 48'(tx_phase_word));
    end
  endtask

  // Random host sample strobe about every fourth cycle
  task automatic host_tick();
    tx_strobe = ($urandom % 4) == 0;
    tx_sample = iq16_t'($urandom);
    tick();
    tx_strobe = 1'b0;
  endtask

  task automatic send_ctrl(input logic [5:0] addr, input logic [31:0] data);
    cmd_req = {addr, data};
    cmd_rqst = 1'b1;
    tick();
    cmd_rqst = 1'b0;
    check_value("cmd_ack_o", 48'd0, 48'(cmd_ack));
    if (addr == `RADIO_ADDR_CTRL) begin
      m_last = data[7:3];
      m_duplex = data[2];
    end else begin
      m_vna = data[23];
    end
    tick();
    check_value("cmd_ack_o", 48'd0, 48'(cmd_ack));
  endtask

  // Ack in the third cycle and the new word one cycle later
  task automatic send_freq(input logic [5:0] addr, input logic [31:0] data);
    logic [31:0] w;
    logic simplex;
    w = phase_model(data);
    simplex = !m_duplex && (m_last == 5'd0);
    cmd_req = {addr, data};
    cmd_rqst = 1'b1;
    for (int n = 1; n <= 4; n++) begin
      tick();
      cmd_rqst = 1'b0;
      check_value("cmd_ack_o", 48'(n == 3), 48'(cmd_ack));
    end
    if (addr == `RADIO_ADDR_TX0) begin
      if (simplex) begin
        m_rx[0] = w;
      end
      m_tx = w;
    end else if (addr == `RADIO_ADDR_RX0) begin
      m_rx[0] = simplex ? m_tx : w;
    end
    for (int c = 1; c < NR; c++) begin
      if (addr == rx_addr(c)) begin
        m_rx[c] = w;
      end
    end
    for (int c = 0; c < NR; c++) begin
      check_value($sformatf("rx_phase_o[%0d]", c), 48'(m_rx[c]), 48'(rx_phase[c]));
    end
  endtask

  // --------------------
  // Upstream frame
  // --------------------

  task automatic rx_frame(input logic ready);
    int beats;
    int waited;
    logic [23:0] exp;
    for (int c = 0; c < NR; c++) begin
      rx_samples[c] = {24'($urandom), 24'($urandom)};
    end
    rx_strobe = 1'b1;
    rx_tready = ready;
    tick();
    rx_strobe = 1'b0;
    beats = ready ? 2 * (int'(m_last) + 1) : 0;
    waited = 0;
    while (rx_tvalid !== 1'b1 && waited < 6) begin
      tick();
      waited++;
    end
    if (ready && rx_tvalid !== 1'b1) begin
      $display("No upstream frame after an accepted strobe at t=%0t", $time);
      errs++;
      beats = 0;
    end else if (!ready && rx_tvalid === 1'b1) begin
      $display("Upstream frame started after a strobe with ready low at t=%0t", $time);
      errs++;
    end
    for (int b = 0; b < beats; b++) begin
      exp = b[0] ? rx_samples[b / 2].q : rx_samples[b / 2].i;
      check_value("rx_tvalid_o", 48'd1, 48'(rx_tvalid));
      check_value("rx_tdata_o", 48'(exp), 48'(rx_tdata));
      check_value("rx_tlast_o", 48'(b == beats - 1), 48'(rx_tlast));
      tick();
    end
    check_value("rx_tvalid_o", 48'd0, 48'(rx_tvalid));
    rx_tready = 1'b1;
  endtask

  task automatic cw_press(input int cycles);
    int n;
    cw_keydown = 1'b1;
    repeat (cycles) host_tick();
    cw_keydown = 1'b0;
    n = 0;
    while (m_cw != 2'd0 && n < `RADIO_CW_MAX + 10) begin
      host_tick();
      n++;
    end
    // Host samples take over again
    repeat (4) host_tick();
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errs == test_errs) begin
      $display("%s: pass", name);
    end else begin
      failed++;
      $display("%s: FAIL with %0d errors", name, errs - test_errs);
    end
    test_errs = errs;
  endtask

  // --------------------
  // Watchdog
  // --------------------

  initial begin
    #(RUN_CYCLES * PERIOD);
    $display("Watchdog expired after %0d cycles", RUN_CYCLES);
    $display("Test failed");
    $finish;
  end

  initial begin
    seed = $urandom(42440);
    {errs, test_errs, tests, failed} = '0;
    rst_n_i = 1'b0;
    {cmd_req, cmd_rqst, cw_keydown, tx_strobe, rx_strobe} = '0;
    rx_tready = 1'b1;
    tx_sample = '0;
    rx_samples = '0;
    {m_tx, m_rx, m_last, m_duplex, m_vna, m_cw, m_level, m_host} = '0;
    repeat (2) tick();
    rst_n_i = 1'b1;
    tick();
    check_value("cmd_ack_o", 48'd0, 48'(cmd_ack));
    check_value("rx_tvalid_o", 48'd0, 48'(rx_tvalid));
    check_value("rx_tlast_o", 48'd0, 48'(rx_tlast));
    for (int c = 0; c < NR; c++) begin
      check_value($sformatf("rx_phase_o[%0d]", c), 48'd0, 48'(rx_phase[c]));
    end
    send_ctrl(`RADIO_ADDR_CTRL, 32'h0000_000c);
    send_ctrl(`RADIO_ADDR_VNA, 32'h0000_0000);
    end_test("reset and control");

    // Duplex, all receivers live
    send_ctrl(`RADIO_ADDR_CTRL, {24'd0, 5'(NR - 1), 3'b100});
    repeat (12) begin
      send_freq(($urandom % 4 == 0) ? `RADIO_ADDR_TX0 : rx_addr($urandom % NR), $urandom);
    end
    end_test("frequency commands");

    // Simplex TX0 writes RX0 too
    send_ctrl(`RADIO_ADDR_CTRL, 32'h0);
    send_freq(`RADIO_ADDR_TX0, $urandom);
    // Duplex RX0 write moves RX0 away from TX0
    send_ctrl(`RADIO_ADDR_CTRL, 32'h4);
    send_freq(`RADIO_ADDR_RX0, $urandom);
    // Simplex RX0 command copies TX0 back
    send_ctrl(`RADIO_ADDR_CTRL, 32'h0);
    send_freq(`RADIO_ADDR_RX0, $urandom);
    end_test("simplex and duplex");

    repeat (6) begin
      send_ctrl(`RADIO_ADDR_CTRL, {24'd0, 5'($urandom % NR), 3'b100});
      rx_frame(1'b1);
    end
    rx_frame(1'b0);
    end_test("upstream framing");

    cw_press(1 + $urandom % 300);
    // Long press up to the peak level
    cw_keydown = 1'b1;
    repeat (`RADIO_CW_MAX + 100) host_tick();
    check_value("tx_iq_o.i", 48'(`RADIO_CW_MAX >> 3), 48'(tx_iq.i));
    cw_press(0);
    end_test("CW envelope");

    send_freq(`RADIO_ADDR_RX0, $urandom);
    send_ctrl(`RADIO_ADDR_VNA, 32'h0080_0000);
    repeat (3) host_tick();
    check_value("tx_iq_o.i", 48'(`RADIO_VNA_LEVEL), 48'(tx_iq.i));
    check_value("tx_phase_word_o", 48'(m_rx[0]), 48'(tx_phase_word));
    send_ctrl(`RADIO_ADDR_VNA, 32'h0);
    repeat (3) host_tick();
    check_value("tx_phase_word_o", 48'(m_tx), 48'(tx_phase_word));
    end_test("VNA selection");

    $display("Tests run %0d, failed %0d, errors %0d", tests, failed, errs);
    if (errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+rtl
rtl/radio_pkg.sv
rtl/cmd_decoder.sv
rtl/freq_word_calc.sv
rtl/rx_upstream.sv
rtl/tx_baseband.sv
rtl/radio_core.sv
bench/radio_tb.sv

// File: run.sh
#!/bin/sh
# Build the radio core testbench with Verilator and run it
rm -f sim.log
verilator --binary --timing -f files.f --top-module radio_tb -o radio_sim > build.log 2>&1 \
  && ./obj_dir/radio_sim > sim.log 2>&1
grep -q "Test completed successfully" sim.log 2>/dev/null \
  && echo "PASS" \
  || { echo "FAIL, see build.log and sim.log"; exit 1; }
